// File: rtl/render_macros.svh
// Screen, tile, sprite and credit dimensions for the arena renderer
// Included by the package and by every RTL file that sizes logic from them
// All values are plain integers so they work in widths and comparisons

`ifndef RENDER_MACROS_SVH
`define RENDER_MACROS_SVH

// ------------------------------
// Visible pixel grid
// ------------------------------
`define SCREEN_WIDTH  160           // Pixels per line
`define SCREEN_HEIGHT 120           // Lines per frame
`define COORD_BITS    8             // Wide enough for either axis

// ------------------------------
// Barrier tile map
// ------------------------------
`define TILE_SHIFT 3                // 8-pixel tiles
`define TILE_COLS  20               // SCREEN_WIDTH >> TILE_SHIFT
`define TILE_ROWS  15               // SCREEN_HEIGHT >> TILE_SHIFT

// ------------------------------
// Sprites and flow control
// ------------------------------
`define SPRITE_SIZE   16            // Square sprite edge
`define NUM_SPRITES   4             // Slot 0 shooter, 1..3 zombies
`define PIXEL_CREDITS 4             // Sink buffer depth

`endif

// File: rtl/renderPkg.sv
// Shared types and colour constants for the arena renderer
// Modules pull these in with a wildcard import of renderPkg
// RGB triples are packed with red in the top channel, blue in the bottom

`include "render_macros.svh"

package renderPkg;

    typedef logic [`COORD_BITS-1:0] coordT;    // One screen coordinate
    typedef logic [7:0]             colorT;    // One colour channel
    typedef colorT [2:0]            rgbT;      // [2] red, [1] green, [0] blue

    // Direction the sprite is looking, selects the eye stripe
    typedef enum logic [1:0]
    {
        faceUp    = 2'd0,
        faceRight = 2'd1,
        faceDown  = 2'd2,
        faceLeft  = 2'd3
    } faceT;

    // ------------------------------
    // Sprite colours
    // ------------------------------
    localparam rgbT slotColors [`NUM_SPRITES] = '{
        {8'h00, 8'hff, 8'h00},      // Shooter, green
        {8'hff, 8'h00, 8'h00},      // Zombie, red
        {8'h80, 8'h00, 8'h80},      // Zombie, purple
        {8'hff, 8'hff, 8'h00}       // Zombie, yellow
    };
    localparam rgbT eyeColor = {8'h00, 8'hff, 8'hff};

    // ------------------------------
    // Arena frame
    // ------------------------------
    localparam rgbT backgroundColor = {8'hf3, 8'h69, 8'h0e};   // Orange surround
    localparam rgbT edgeColor       = {8'h00, 8'h00, 8'h00};
    localparam rgbT floorColor      = {8'h00, 8'h00, 8'hff};
    localparam rgbT barrierColor    = {8'h80, 8'h80, 8'h80};

    // Rectangle bounds, all inclusive
    localparam coordT edgeLeft    = coordT'(2);
    localparam coordT edgeRight   = coordT'(157);
    localparam coordT edgeTop     = coordT'(6);
    localparam coordT edgeBottom  = coordT'(115);
    localparam coordT floorLeft   = coordT'(4);
    localparam coordT floorRight  = coordT'(155);
    localparam coordT floorTop    = coordT'(8);
    localparam coordT floorBottom = coordT'(113);

endpackage

// File: rtl/scanGenerator.sv
// Raster scan source for the renderer pipeline
// Walks the screen X-fastest and issues one coordinate per cycle while it
// holds a credit from the display sink; each creditReturn pulse adds one back
// frameStart marks the issue of pixel (0,0)

`include "render_macros.svh"

module scanGenerator
    import renderPkg::*;
(
    input  logic  Clk,
    input  logic  reset,
    input  logic  creditReturn,        // One pulse per pixel the sink consumed
    output logic  scanValid,
    output logic  frameStart,
    output coordT scanX,
    output coordT scanY
);

    localparam int    CREDIT_BITS = $clog2(`PIXEL_CREDITS + 1);
    localparam coordT LAST_X      = coordT'(`SCREEN_WIDTH - 1);
    localparam coordT LAST_Y      = coordT'(`SCREEN_HEIGHT - 1);

    logic [CREDIT_BITS-1:0] creditCount;
    logic                   issue;
    coordT                  rasterX;   // Next coordinate to hand out
    coordT                  rasterY;

    assign issue = (creditCount != '0);    // Any credit left lets a pixel go

    // ------------------------------
    // Credit counter
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
            creditCount <= CREDIT_BITS'(`PIXEL_CREDITS);   // Sink buffer starts empty
        else
        begin
            case ({issue, creditReturn})
                2'b10:   creditCount <= creditCount - 1'b1;  // Spend
                2'b01:   creditCount <= creditCount + 1'b1;  // Refund
                default: creditCount <= creditCount;         // Both or neither
            endcase
        end
    end

    // ------------------------------
    // Raster counters and issue flags
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            rasterX    <= '0;
            rasterY    <= '0;
            scanValid  <= 1'b0;
            frameStart <= 1'b0;
        end
        else
        begin
            scanValid  <= issue;
            frameStart <= issue && (rasterX == '0) && (rasterY == '0);
            if (issue)
            begin
                if (rasterX == LAST_X)
                begin
                    rasterX <= '0;
                    rasterY <= (rasterY == LAST_Y) ? '0 : rasterY + 1'b1;  // Frame wrap
                end
                else
                    rasterX <= rasterX + 1'b1;
            end
        end
    end

    // Issued coordinate, only meaningful with scanValid
    always_ff @(posedge Clk)
    begin
        if (issue)
        begin
            scanX <= rasterX;
            scanY <= rasterY;
        end
    end

endmodule

// File: rtl/spriteEngine.sv
// Hit test and texel lookup for one sprite slot
// Stage 1 latches the sprite placement at frameStart and finds the pixel's
// offset inside the 16x16 box; stage 2 applies the texel rule and registers
// hitOpaque and hitColor two cycles after the scan coordinate
// SLOT picks the body colour out of slotColors

`include "render_macros.svh"

module spriteEngine
    import renderPkg::*;
#(
    parameter int SLOT = 0
)
(
    input  logic  Clk,
    input  logic  reset,
    input  logic  scanValid,
    input  logic  frameStart,
    input  coordT scanX,
    input  coordT scanY,
    input  coordT spriteX,             // Upper-left corner
    input  coordT spriteY,
    input  faceT  spriteFace,
    input  logic  spriteLive,
    output logic  hitOpaque,
    output rgbT   hitColor
);

    localparam int OFF_BITS = $clog2(`SPRITE_SIZE);
    localparam int OFF_MAX  = `SPRITE_SIZE - 1;

    // Per-frame copy of the sprite inputs
    coordT latchX;
    coordT latchY;
    faceT  latchFace;
    logic  latchLive;

    // Values in force for the current pixel
    coordT curX;
    coordT curY;
    faceT  curFace;
    logic  curLive;
    coordT diffX;
    coordT diffY;

    // Stage 1 registers
    logic                valid1;
    logic                inBox1;
    logic                live1;
    faceT                face1;
    logic [OFF_BITS-1:0] offX1;
    logic [OFF_BITS-1:0] offY1;

    logic corner;
    logic stripe;

    // ------------------------------
    // Stage 1: placement and box test
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
            latchLive <= 1'b0;
        else if (scanValid && frameStart)
        begin
            latchX    <= spriteX;
            latchY    <= spriteY;
            latchFace <= spriteFace;
            latchLive <= spriteLive;
        end
    end

    // First pixel of a frame already sees the new placement
    assign curX    = frameStart ? spriteX    : latchX;
    assign curY    = frameStart ? spriteY    : latchY;
    assign curFace = frameStart ? spriteFace : latchFace;
    assign curLive = frameStart ? spriteLive : latchLive;

    assign diffX = scanX - curX;       // Left of the sprite wraps to a large value
    assign diffY = scanY - curY;

    always_ff @(posedge Clk)
    begin
        if (reset)
            valid1 <= 1'b0;
        else
            valid1 <= scanValid;
    end

    always_ff @(posedge Clk)
    begin
        inBox1 <= (diffX < `SPRITE_SIZE) && (diffY < `SPRITE_SIZE);
        live1  <= curLive;
        face1  <= curFace;
        offX1  <= diffX[OFF_BITS-1:0];
        offY1  <= diffY[OFF_BITS-1:0];
    end

    // ------------------------------
    // Stage 2: texel rule
    // ------------------------------
    // 2x2 squares in each corner are see-through
    assign corner = ((offX1 < 2) || (offX1 > OFF_MAX - 2)) &&
                    ((offY1 < 2) || (offY1 > OFF_MAX - 2));

    // Eyes: 3-pixel band on the side the sprite looks towards
    always_comb
    begin
        case (face1)
            faceUp:    stripe = (offY1 < 3);
            faceDown:  stripe = (offY1 > OFF_MAX - 3);
            faceLeft:  stripe = (offX1 < 3);
            default:   stripe = (offX1 > OFF_MAX - 3);    // faceRight
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (reset)
            hitOpaque <= 1'b0;
        else
            hitOpaque <= valid1 && live1 && inBox1 && !corner;
    end

    always_ff @(posedge Clk)
        hitColor <= stripe ? eyeColor : slotColors[SLOT];   // Only read when opaque

endmodule

// File: rtl/colorMapper.sv
// Final pixel composition for the arena renderer
// Delays the scan coordinate two cycles to meet the sprite engine results,
// then layers frame, sprites and barrier tiles and registers the RGB output
// Priority, lowest first: frame rectangles, sprites by slot, barriers

`include "render_macros.svh"

module colorMapper
    import renderPkg::*;
(
    input  logic                                   Clk,
    input  logic                                   reset,
    input  logic                                   scanValid,
    input  coordT                                  scanX,
    input  coordT                                  scanY,
    input  logic [`NUM_SPRITES-1:0]                hitOpaque,
    input  rgbT  [`NUM_SPRITES-1:0]                hitColor,
    input  logic [`TILE_ROWS-1:0][`TILE_COLS-1:0] barrierMap,  // [row][col]
    output logic                                   pixelValid,
    output coordT                                  pixelX,
    output coordT                                  pixelY,
    output colorT                                  pixelRed,
    output colorT                                  pixelGreen,
    output colorT                                  pixelBlue
);

    localparam int TILE_BITS = `COORD_BITS - `TILE_SHIFT;

    // Alignment pipe, matches the two engine stages
    logic  valid1;
    logic  valid2;
    coordT x1;
    coordT y1;
    coordT x2;
    coordT y2;

    logic                 inEdge;
    logic                 inFloor;
    logic [TILE_BITS-1:0] tileRow;
    logic [TILE_BITS-1:0] tileCol;
    rgbT                  color;

    // ------------------------------
    // Coordinate alignment
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
        end
        else
        begin
            valid1 <= scanValid;
            valid2 <= valid1;
        end
    end

    always_ff @(posedge Clk)
    begin
        x1 <= scanX;
        y1 <= scanY;
        x2 <= x1;
        y2 <= y1;
    end

    // ------------------------------
    // Layer priority
    // ------------------------------
    assign inEdge  = (x2 >= edgeLeft) && (x2 <= edgeRight) &&
                     (y2 >= edgeTop)  && (y2 <= edgeBottom);
    assign inFloor = (x2 >= floorLeft) && (x2 <= floorRight) &&
                     (y2 >= floorTop)  && (y2 <= floorBottom);

    assign tileRow = y2[`COORD_BITS-1:`TILE_SHIFT];   // Divide by tile size
    assign tileCol = x2[`COORD_BITS-1:`TILE_SHIFT];

    always_comb
    begin
        color = backgroundColor;
        if (inEdge)
            color = edgeColor;                 // Black rim around the floor
        if (inFloor)
            color = floorColor;

        // Later slots overwrite earlier ones
        for (int s = 0; s < `NUM_SPRITES; s++)
        begin
            if (hitOpaque[s])
                color = hitColor[s];
        end

        if (barrierMap[tileRow][tileCol])
            color = barrierColor;              // Walls cover everything
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
            pixelValid <= 1'b0;
        else
            pixelValid <= valid2;
    end

    always_ff @(posedge Clk)
    begin
        pixelX     <= x2;
        pixelY     <= y2;
        pixelRed   <= color[2];
        pixelGreen <= color[1];
        pixelBlue  <= color[0];
    end

endmodule

// File: rtl/pixelRenderer.sv
// Top of the streaming arena renderer
// The scan generator feeds NUM_SPRITES sprite engines and the colour mapper;
// a pixel issued in cycle t leaves on pixelValid in cycle t+3
// The sink returns one creditReturn pulse per consumed pixel

`include "render_macros.svh"

module pixelRenderer
    import renderPkg::*;
(
    input  logic                                   Clk,
    input  logic                                   reset,
    input  coordT [`NUM_SPRITES-1:0]               spriteX,     // Per slot, 0 is shooter
    input  coordT [`NUM_SPRITES-1:0]               spriteY,
    input  faceT  [`NUM_SPRITES-1:0]               spriteFace,
    input  logic  [`NUM_SPRITES-1:0]               spriteLive,
    input  logic [`TILE_ROWS-1:0][`TILE_COLS-1:0] barrierMap,
    input  logic                                   creditReturn,
    output logic                                   pixelValid,
    output coordT                                  pixelX,
    output coordT                                  pixelY,
    output colorT                                  pixelRed,
    output colorT                                  pixelGreen,
    output colorT                                  pixelBlue
);

    logic                    scanValid;
    logic                    frameStart;
    coordT                   scanX;
    coordT                   scanY;
    logic [`NUM_SPRITES-1:0] hitOpaque;
    rgbT  [`NUM_SPRITES-1:0] hitColor;

    scanGenerator scanGenerator_i (
        .Clk          (Clk),
        .reset        (reset),
        .creditReturn (creditReturn),
        .scanValid    (scanValid),
        .frameStart   (frameStart),
        .scanX        (scanX),
        .scanY        (scanY)
    );

    // ------------------------------
    // One engine per sprite slot
    // ------------------------------
    for (genvar slot = 0; slot < `NUM_SPRITES; slot++)
    begin : gSprite
        spriteEngine #(.SLOT(slot)) spriteEngine_i (
            .Clk        (Clk),
            .reset      (reset),
            .scanValid  (scanValid),
            .frameStart (frameStart),
            .scanX      (scanX),
            .scanY      (scanY),
            .spriteX    (spriteX[slot]),
            .spriteY    (spriteY[slot]),
            .spriteFace (spriteFace[slot]),
            .spriteLive (spriteLive[slot]),
            .hitOpaque  (hitOpaque[slot]),
            .hitColor   (hitColor[slot])
        );
    end

    colorMapper colorMapper_i (
        .Clk        (Clk),
        .reset      (reset),
        .scanValid  (scanValid),
        .scanX      (scanX),
        .scanY      (scanY),
        .hitOpaque  (hitOpaque),
        .hitColor   (hitColor),
        .barrierMap (barrierMap),
        .pixelValid (pixelValid),
        .pixelX     (pixelX),
        .pixelY     (pixelY),
        .pixelRed   (pixelRed),
        .pixelGreen (pixelGreen),
        .pixelBlue  (pixelBlue)
    );

endmodule

// File: dv/pixelRenderer_properties.sv
// Bound checker for the arena renderer top level
// Rebuilds each output colour from the frame, sprite and barrier rules and
// tracks raster position and credits; errorCount is read by the testbench

`include "render_macros.svh"

module pixelRenderer_properties
    import renderPkg::*;
(
    input logic                                   Clk,
    input logic                                   reset,
    input coordT [`NUM_SPRITES-1:0]               spriteX,
    input coordT [`NUM_SPRITES-1:0]               spriteY,
    input faceT  [`NUM_SPRITES-1:0]               spriteFace,
    input logic  [`NUM_SPRITES-1:0]               spriteLive,
    input logic [`TILE_ROWS-1:0][`TILE_COLS-1:0] barrierMap,
    input logic                                   creditReturn,
    input logic                                   pixelValid,
    input coordT                                  pixelX,
    input coordT                                  pixelY,
    input colorT                                  pixelRed,
    input colorT                                  pixelGreen,
    input colorT                                  pixelBlue
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAYER_FRAME   = 0;
    localparam int LAYER_SPRITE  = 1;
    localparam int LAYER_BARRIER = 2;

    int    errorCount = 0;             // Failed assertions so far
    int    layer;                      // Topmost layer expected at the pixel
    int    outstanding;                // Pixels out minus credits back
    int    sinceReset;                 // Saturates at 3
    rgbT   expRgb;
    rgbT   outRgb;
    coordT expX;                       // Next raster position expected
    coordT expY;

    assign outRgb = {pixelRed, pixelGreen, pixelBlue};

    // ------------------------------
    // Colour rules
    // ------------------------------
    function automatic rgbT frameColor(input int x, input int y);
        if (x >= 4 && x <= 155 && y >= 8 && y <= 113)
            return floorColor;
        if (x >= 2 && x <= 157 && y >= 6 && y <= 115)
            return edgeColor;              // Rim left around the floor
        return backgroundColor;
    endfunction

    function automatic bit isCorner(input int dx, input int dy);
        return (dx < 2 || dx >= `SPRITE_SIZE - 2) && (dy < 2 || dy >= `SPRITE_SIZE - 2);
    endfunction

    function automatic bit inEyeStripe(input faceT face, input int dx, input int dy);
        case (face)
            faceUp:   return dy < 3;
            faceDown: return dy >= `SPRITE_SIZE - 3;
            faceLeft: return dx < 3;
            default:  return dx >= `SPRITE_SIZE - 3;   // Facing right
        endcase
    endfunction

    always_comb
    begin : expectation
        int dx;
        int dy;
        layer  = LAYER_FRAME;
        expRgb = frameColor(int'(pixelX), int'(pixelY));
        for (int s = 0; s < `NUM_SPRITES; s++)     // Higher slot painted last
        begin
            dx = int'(pixelX) - int'(spriteX[s]);
            dy = int'(pixelY) - int'(spriteY[s]);
            if (spriteLive[s] && dx >= 0 && dx < `SPRITE_SIZE && dy >= 0 &&
                dy < `SPRITE_SIZE && !isCorner(dx, dy))
            begin
                layer  = LAYER_SPRITE;
                expRgb = inEyeStripe(spriteFace[s], dx, dy) ? eyeColor : slotColors[s];
            end
        end
        if (barrierMap[pixelY[`COORD_BITS-1:`TILE_SHIFT]][pixelX[`COORD_BITS-1:`TILE_SHIFT]])
        begin
            layer  = LAYER_BARRIER;
            expRgb = barrierColor;
        end
    end

    // ------------------------------
    // Raster and credit tracking
    // ------------------------------
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            expX        <= '0;
            expY        <= '0;
            outstanding <= 0;
            sinceReset  <= 0;
        end
        else
        begin
            if (sinceReset < 3)
                sinceReset <= sinceReset + 1;
            outstanding <= outstanding + int'(pixelValid) - int'(creditReturn);
            if (pixelValid)
            begin
                if (expX == coordT'(`SCREEN_WIDTH - 1))
                begin
                    expX <= '0;
                    expY <= (expY == coordT'(`SCREEN_HEIGHT - 1)) ? '0 : expY + 1'b1;
                end
                else
                    expX <= expX + 1'b1;
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    aFrameColor: assert property (@(posedge Clk) disable iff (reset)
        (pixelValid && layer == LAYER_FRAME) |-> (outRgb == expRgb))
        else
        begin
            errorCount++;
            $error("mismatch at %0t: pixelRed/pixelGreen/pixelBlue frame got %h expected %h",
                   $time, $sampled(outRgb), $sampled(expRgb));
        end

    aSpriteColor: assert property (@(posedge Clk) disable iff (reset)
        (pixelValid && layer == LAYER_SPRITE) |-> (outRgb == expRgb))
        else
        begin
            errorCount++;
            $error("mismatch at %0t: pixelRed/pixelGreen/pixelBlue sprite got %h expected %h",
                   $time, $sampled(outRgb), $sampled(expRgb));
        end

    aBarrierColor: assert property (@(posedge Clk) disable iff (reset)
        (pixelValid && layer == LAYER_BARRIER) |-> (outRgb == barrierColor))
        else
        begin
            errorCount++;
            $error("mismatch at %0t: pixelRed/pixelGreen/pixelBlue barrier got %h expected %h",
                   $time, $sampled(outRgb), barrierColor);
        end

    aRasterOrder: assert property (@(posedge Clk) disable iff (reset)
        pixelValid |-> (pixelX == expX && pixelY == expY))
        else
        begin
            errorCount++;
            $error("mismatch at %0t: pixelX/pixelY got (%0d,%0d) expected (%0d,%0d)", $time,
                   $sampled(pixelX), $sampled(pixelY), $sampled(expX), $sampled(expY));
        end

    aCreditLimit: assert property (@(posedge Clk) disable iff (reset)
        outstanding <= `PIXEL_CREDITS)
        else
        begin
            errorCount++;
            $error("at %0t %0d pixels were out without a returned credit, the limit is %0d",
                   $time, $sampled(outstanding), `PIXEL_CREDITS);
        end

    aQuietAfterReset: assert property (@(posedge Clk) disable iff (reset)
        (sinceReset < 3) |-> !pixelValid)
        else
        begin
            errorCount++;
            $error("at %0t pixelValid rose within three cycles of reset release", $time);
        end

endmodule

bind pixelRenderer pixelRenderer_properties pixelRendererProps_i (
    .Clk          (Clk),
    .reset        (reset),
    .spriteX      (spriteX),
    .spriteY      (spriteY),
    .spriteFace   (spriteFace),
    .spriteLive   (spriteLive),
    .barrierMap   (barrierMap),
    .creditReturn (creditReturn),
    .pixelValid   (pixelValid),
    .pixelX       (pixelX),
    .pixelY       (pixelY),
    .pixelRed     (pixelRed),
    .pixelGreen   (pixelGreen),
    .pixelBlue    (pixelBlue)
);

// File: dv/pixelRendererTb.sv
// Testbench for the arena pixel renderer
// Runs four frames of sprite and barrier scenes through a credit-returning
// sink; the bound checker does the colour, raster and credit checks
// Credits are held back at each frame end so scenes change with the pipe empty

`include "render_macros.svh"

module pixelRendererTb
    import renderPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_PIXELS = `SCREEN_WIDTH * `SCREEN_HEIGHT;
    localparam int FRAME_LIMIT  = 200000;          // Cycles allowed per frame
    localparam int RUN_LIMIT    = 1000000;         // Cycles allowed for the run
    localparam int NUM_FRAMES   = 4;

    typedef logic [`TILE_COLS-1:0] tileRowT;

    logic                                   Clk;
    logic                                   reset;
    coordT [`NUM_SPRITES-1:0]               spriteX;
    coordT [`NUM_SPRITES-1:0]               spriteY;
    faceT  [`NUM_SPRITES-1:0]               spriteFace;
    logic  [`NUM_SPRITES-1:0]               spriteLive;
    logic [`TILE_ROWS-1:0][`TILE_COLS-1:0] barrierMap;
    logic                                   creditReturn;
    logic                                   pixelValid;
    coordT                                  pixelX;
    coordT                                  pixelY;
    colorT                                  pixelRed;
    colorT                                  pixelGreen;
    colorT                                  pixelBlue;

    int target   = 0;                  // Pixels the sink accepts so far
    int received = 0;                  // Pixels the sink has recorded
    int checkerErrors;

    assign checkerErrors = pixelRenderer_i.pixelRendererProps_i.errorCount;

    pixelRenderer pixelRenderer_i (.*);

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;         // 8 ns period
    end

    // ------------------------------
    // Display sink
    // ------------------------------
    // Returns each credit 0..6 cycles after its pixel, stops short of target
    task automatic returnCredits();
        int dueCycle[$];
        int returned;
        int cycle;
        returned = 0;
        cycle    = 0;
        creditReturn <= 1'b0;
        forever
        begin
            @(posedge Clk);
            cycle++;
            if (pixelValid)
            begin
                received <= received + 1;
                dueCycle.push_back(cycle + int'($urandom % 7));
            end
            if (dueCycle.size() > 0 && dueCycle[0] <= cycle &&
                returned + `PIXEL_CREDITS < target)
            begin
                creditReturn <= 1'b1;
                returned++;
                void'(dueCycle.pop_front());
            end
            else
                creditReturn <= 1'b0;
        end
    endtask

    // ------------------------------
    // Scenes
    // ------------------------------
    task automatic placeSprite(input int slot, input int x, input int y,
                               input faceT face, input bit live);
        spriteX[slot]    <= coordT'(x);
        spriteY[slot]    <= coordT'(y);
        spriteFace[slot] <= face;
        spriteLive[slot] <= live;
    endtask

    task automatic placeFrame(input int frame);
        logic [`TILE_ROWS-1:0][`TILE_COLS-1:0] map;
        map = '0;
        case (frame)
            0:                                     // Open floor, one facing each
            begin
                placeSprite(0, 40, 40, faceRight, 1'b1);
                placeSprite(1, 80, 30, faceUp, 1'b1);
                placeSprite(2, 100, 70, faceDown, 1'b1);
                placeSprite(3, 20, 80, faceLeft, 1'b1);
            end
            1:                                     // Stacked pile in the middle
            begin
                placeSprite(0, 60, 50, faceUp, 1'b1);
                placeSprite(1, 66, 54, faceRight, 1'b1);
                placeSprite(2, 70, 58, faceDown, 1'b1);
                placeSprite(3, 64, 60, faceLeft, 1'b1);
            end
            2:                                     // Zombies dead, shooter in corner
            begin
                placeSprite(0, 144, 104, faceLeft, 1'b1);
                placeSprite(1, 50, 50, faceUp, 1'b0);
                placeSprite(2, 140, 100, faceRight, 1'b0);
                placeSprite(3, 0, 0, faceDown, 1'b0);
            end
            default:                               // Random walls over the actors
            begin
                for (int r = 0; r < `TILE_ROWS; r++)
                    map[r] = tileRowT'($urandom);
                map[5][5] = 1'b1;                  // Shooter top-left tile
                placeSprite(0, 40, 40, faceDown, 1'b1);
                placeSprite(1, 90, 60, faceLeft, 1'b1);
                placeSprite(2, 96, 64, faceUp, 1'b1);
                placeSprite(3, 10, 100, faceRight, 1'b1);
            end
        endcase
        barrierMap <= map;
    endtask

    // Opens credits for one more frame and waits until all of it arrived
    task automatic waitFrame(output bit done);
        int waited;
        waited = 0;
        target <= target + FRAME_PIXELS;
        @(posedge Clk);
        while (received < target && waited < FRAME_LIMIT)
        begin
            @(posedge Clk);
            waited++;
        end
        done = (received >= target);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial
    begin : stimulus
        bit done;
        int frame;
        void'($urandom(50));
        fork
            returnCredits();
        join_none
        reset <= 1'b1;
        placeFrame(0);                 // Latched by the first frameStart
        repeat (5) @(posedge Clk);
        reset <= 1'b0;
        done  = 1'b1;
        for (frame = 0; frame < NUM_FRAMES && done; frame++)
        begin
            if (frame > 0)
            begin
                @(posedge Clk);
                placeFrame(frame);
            end
            waitFrame(done);
        end
        if (done && checkerErrors == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("SOME TESTS FAILED");
            if (!done)
                $fatal(1, "frame %0d did not complete within %0d cycles", frame, FRAME_LIMIT);
            else
                $fatal(1, "an assertion of the bound checker failed");
        end
    end

    // Stops the run at the first checker failure or when it runs too long
    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (checkerErrors == 0 && cycles < RUN_LIMIT)
        begin
            @(negedge Clk);
            cycles++;
        end
        $display("SOME TESTS FAILED");
        if (checkerErrors != 0)
            $fatal(1, "an assertion of the bound checker failed");
        else
            $fatal(1, "run did not finish within %0d cycles", RUN_LIMIT);
    end

endmodule

// File: src.f
+incdir+rtl
rtl/renderPkg.sv
rtl/scanGenerator.sv
rtl/spriteEngine.sv
rtl/colorMapper.sv
rtl/pixelRenderer.sv
dv/pixelRenderer_properties.sv
dv/pixelRendererTb.sv

// File: Makefile
# Verilator flow for the arena pixel renderer

VERILATOR  ?= verilator
TOP        := pixelRendererTb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+100
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
